/* src/pic_bus_pkg.sv */
`default_nettype none

package pic_bus_pkg;

	// ======================================================================
	// register port word types
	// ======================================================================

	// byte address from the cpu side
	typedef logic [31:0] bus_addr_t;
	// read and write data word
	typedef logic [31:0] bus_data_t;
	// word offset inside the controller window, adr[7:2]
	typedef logic [5:0] reg_off_t;

	// controller window, only adr[31:8] takes part in the decode
	localparam bus_addr_t PIC_BASE = 32'hffdc_0f00;

	// ======================================================================
	// register map, word offsets
	// ======================================================================

	// winner's cause code, read only
	localparam reg_off_t REG_CAUSE    = 6'd0;
	// whole enable vector
	localparam reg_off_t REG_IE       = 6'd1;
	// data[4:0] names the source whose enable is cleared
	localparam reg_off_t REG_IE_CLR   = 6'd2;
	// data[4:0] names the source whose enable is set
	localparam reg_off_t REG_IE_SET   = 6'd3;
	// edge select vector, 1 = edge sensitive
	localparam reg_off_t REG_ES       = 6'd4;
	// data[4:0] names the edge latch to clear
	localparam reg_off_t REG_EDGE_RST = 6'd5;
	// data[4:0] names the source to trigger from software
	localparam reg_off_t REG_TRIG     = 6'd6;
	// per-source control words, word index = 32 + source number
	localparam reg_off_t REG_CTL_BASE = 6'd32;

	// control word fields
	localparam int CTL_CAUSE_LSB = 0;
	localparam int CTL_LEVEL_LSB = 8;
	localparam int CTL_IE_BIT    = 16;
	localparam int CTL_ES_BIT    = 17;

endpackage

`default_nettype wire

/* src/pic_irq_pkg.sv */
`default_nettype none

package pic_irq_pkg;

	// ======================================================================
	// request side widths
	// ======================================================================

	// number of request lines, line 0 is the nmi
	localparam int NUM_SRC = 32;

	// source number, 0 also stands for no request
	typedef logic [$clog2(NUM_SRC)-1:0] src_idx_t;
	// one bit per source
	typedef logic [NUM_SRC-1:0] src_vec_t;
	// processor priority level handed to the cpu
	typedef logic [3:0] irq_level_t;
	// cause code handed to the cpu
	typedef logic [7:0] cause_t;

	// ======================================================================
	// reset values
	// ======================================================================

	// mid-range level until software programs the line
	localparam irq_level_t LEVEL_RST = 4'h8;
	// causes start out cleared
	localparam cause_t CAUSE_RST = 8'h00;
	// every line edge sensitive out of reset
	localparam src_vec_t ES_RST = '1;

endpackage

`default_nettype wire

/* src/pic_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module pic_regs
(
	input  wire logic                    clk,
	input  wire logic                    rst_i,
	input  wire logic                    cyc_i,
	input  wire logic                    stb_i,
	input  wire logic                    wr_i,
	input  wire pic_bus_pkg::bus_addr_t  adr_i,
	input  wire pic_bus_pkg::bus_data_t  dat_i,
	output pic_bus_pkg::bus_data_t       dat_o,
	output logic                         ack_o,
	output logic                         vol_o,
	input  wire pic_irq_pkg::src_idx_t   winner_i,
	output pic_irq_pkg::src_vec_t        ie_o,
	output pic_irq_pkg::src_vec_t        es_o,
	output pic_irq_pkg::src_vec_t        trig_o,
	output pic_irq_pkg::src_vec_t        edge_rst_o,
	output pic_irq_pkg::irq_level_t [pic_irq_pkg::NUM_SRC-1:0] level_tbl_o,
	output pic_irq_pkg::cause_t [pic_irq_pkg::NUM_SRC-1:0]     cause_tbl_o
);

	import pic_bus_pkg::*;
	import pic_irq_pkg::*;

	logic       sel;
	reg_off_t   off;
	logic       is_ctl;
	src_idx_t   ctl_idx;
	src_idx_t   cmd_idx;
	logic       rd_dly;
	bus_data_t  rd_data;
	bus_data_t  rd_q;
	src_vec_t   ie_q;
	src_vec_t   es_q;
	src_vec_t   trig_q;
	src_vec_t   edge_rst_q;
	irq_level_t [NUM_SRC-1:0] level_q;
	cause_t [NUM_SRC-1:0]     cause_q;

	// ======================================================================
	// decode
	// ======================================================================

	// window hit on the upper 24 address bits
	assign sel = cyc_i && stb_i && (adr_i[31:8] == PIC_BASE[31:8]);
	assign vol_o = sel;

	// word offset, top half of the window is the control block
	assign off = adr_i[7:2];
	assign is_ctl = off[5];
	assign ctl_idx = off[4:0];
	// single-source commands carry the source number in the data
	assign cmd_idx = dat_i[4:0];

	// read data shows one cycle into the select
	always_ff @(posedge clk)
	begin
		if (rst_i)
			rd_dly <= 1'b0;
		else
			rd_dly <= sel && !wr_i;
	end

	// writes finish in the select cycle
	assign ack_o = sel && (wr_i || rd_dly);

	// ======================================================================
	// read path
	// ======================================================================

	always_comb
	begin
		rd_data = '0;
		if (is_ctl)
		begin
			// control word, same layout as the write side
			rd_data[CTL_CAUSE_LSB +: $bits(cause_t)] = cause_q[ctl_idx];
			rd_data[CTL_LEVEL_LSB +: $bits(irq_level_t)] = level_q[ctl_idx];
			rd_data[CTL_IE_BIT] = ie_q[ctl_idx];
			rd_data[CTL_ES_BIT] = es_q[ctl_idx];
		end
		else
		begin
			case (off)
				// no winner reads back as zero
				REG_CAUSE:
				begin
					if (winner_i != '0)
						rd_data[CTL_CAUSE_LSB +: $bits(cause_t)] = cause_q[winner_i];
				end
				REG_IE:  rd_data = ie_q;
				REG_ES:  rd_data = es_q;
				// command registers are write only
				default: rd_data = '0;
			endcase
		end
	end

	// capture while selected, dropped otherwise
	always_ff @(posedge clk)
	begin
		if (sel)
			rd_q <= rd_data;
		else
			rd_q <= '0;
	end

	// bus sees data only in the read ack cycle
	assign dat_o = (sel && rd_dly) ? rd_q : '0;

	// ======================================================================
	// software registers
	// ======================================================================

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ie_q <= '0;
			es_q <= ES_RST;
			trig_q <= '0;
			edge_rst_q <= '0;
			for (int n = 0; n < NUM_SRC; n++)
			begin
				level_q[n] <= LEVEL_RST;
				cause_q[n] <= CAUSE_RST;
			end
		end
		else
		begin
			// trigger and edge reset live for one cycle only
			trig_q <= '0;
			edge_rst_q <= '0;
			if (sel && wr_i)
			begin
				if (is_ctl)
				begin
					cause_q[ctl_idx] <= dat_i[CTL_CAUSE_LSB +: $bits(cause_t)];
					level_q[ctl_idx] <= dat_i[CTL_LEVEL_LSB +: $bits(irq_level_t)];
					ie_q[ctl_idx] <= dat_i[CTL_IE_BIT];
					es_q[ctl_idx] <= dat_i[CTL_ES_BIT];
				end
				else
				begin
					case (off)
						REG_IE:       ie_q <= dat_i;
						REG_IE_CLR:   ie_q[cmd_idx] <= 1'b0;
						REG_IE_SET:   ie_q[cmd_idx] <= 1'b1;
						REG_ES:       es_q <= dat_i;
						REG_EDGE_RST: edge_rst_q[cmd_idx] <= 1'b1;
						REG_TRIG:     trig_q[cmd_idx] <= 1'b1;
						// writes to the cause word are ignored
						default:      ;
					endcase
				end
			end
		end
	end

	assign ie_o = ie_q;
	assign es_o = es_q;
	assign trig_o = trig_q;
	assign edge_rst_o = edge_rst_q;
	assign level_tbl_o = level_q;
	assign cause_tbl_o = cause_q;

	// ======================================================================
	// checks
	// ======================================================================

	// a read ack needs the select held over two cycles
	a_ack_sel: assert property (@(posedge clk) disable iff (rst_i)
		ack_o |-> sel && (wr_i || $past(sel)));

	// a command names at most one source
	a_cmd_onehot: assert property (@(posedge clk) disable iff (rst_i)
		$onehot0(trig_o) && $onehot0(edge_rst_o));

endmodule

`default_nettype wire

/* src/pic_sense.sv */
`timescale 1ns/1ps
`default_nettype none

module pic_sense
(
	input  wire logic                  clk,
	input  wire logic                  rst_i,
	input  wire pic_irq_pkg::src_vec_t req_i,
	input  wire pic_irq_pkg::src_vec_t es_i,
	input  wire pic_irq_pkg::src_vec_t ie_i,
	input  wire pic_irq_pkg::src_vec_t trig_i,
	input  wire pic_irq_pkg::src_vec_t edge_rst_i,
	output pic_irq_pkg::src_vec_t      pending_o
);

	import pic_irq_pkg::*;

	src_vec_t req_q;
	src_vec_t latch_q;
	src_vec_t latch_d;
	src_vec_t pend_d;
	src_vec_t pend_q;

	// ======================================================================
	// edge latches and pending vector
	// ======================================================================

	always_comb
	begin
		// set on a rising input or a software trigger
		// clear wins over set
		latch_d = (latch_q | (req_i & ~req_q) | trig_i) & ~edge_rst_i;
		// nmi has no latch
		latch_d[0] = 1'b0;

		// edge lines use the latch, level lines the live sample
		pend_d = ie_i & ((es_i & latch_d) | (~es_i & req_i));
		// nmi goes around the encoder
		pend_d[0] = 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			req_q <= '0;
			latch_q <= '0;
			pend_q <= '0;
		end
		else
		begin
			// previous sample for the edge detect
			req_q <= req_i;
			latch_q <= latch_d;
			pend_q <= pend_d;
		end
	end

	assign pending_o = pend_q;

	// nmi never reaches the encoder
	a_no_nmi_pend: assert property (@(posedge clk) disable iff (rst_i)
		!pending_o[0]);

endmodule

`default_nettype wire

/* src/pic_prio_enc.sv */
`timescale 1ns/1ps
`default_nettype none

module pic_prio_enc
(
	input  wire logic                  clk,
	input  wire logic                  rst_i,
	input  wire pic_irq_pkg::src_vec_t pending_i,
	output pic_irq_pkg::src_idx_t      winner_o
);

	import pic_irq_pkg::*;

	src_idx_t win_d;
	src_idx_t win_q;

	// ======================================================================
	// lowest index first
	// ======================================================================

	always_comb
	begin
		// zero doubles as no request
		win_d = '0;
		// scan downward so the lowest set bit is written last
		for (int n = NUM_SRC - 1; n > 0; n--)
		begin
			if (pending_i[n])
				win_d = src_idx_t'(n);
		end
	end

	// held for a full cycle so the cpu lines never glitch
	always_ff @(posedge clk)
	begin
		if (rst_i)
			win_q <= '0;
		else
			win_q <= win_d;
	end

	assign winner_o = win_q;

	// a winner was pending one cycle before it shows
	a_win_pending: assert property (@(posedge clk) disable iff (rst_i)
		(winner_o != '0) |-> |($past(pending_i) & (src_vec_t'(1) << winner_o)));

endmodule

`default_nettype wire

/* src/pic_out.sv */
`timescale 1ns/1ps
`default_nettype none

module pic_out
(
	input  wire pic_irq_pkg::src_idx_t winner_i,
	input  wire pic_irq_pkg::irq_level_t [pic_irq_pkg::NUM_SRC-1:0] level_tbl_i,
	input  wire pic_irq_pkg::cause_t [pic_irq_pkg::NUM_SRC-1:0]     cause_tbl_i,
	input  wire logic                  nmi_en_i,
	input  wire logic                  nmi_i,
	output pic_irq_pkg::irq_level_t    irq_o,
	output pic_irq_pkg::cause_t        cause_o,
	output logic                       nmi_o
);

	import pic_irq_pkg::*;

	logic has_win;

	// ======================================================================
	// cpu side lines
	// ======================================================================

	// source 0 is never a winner, index 0 means idle
	assign has_win = (winner_i != '0);

	// level and cause come from the winner's table entry
	assign irq_o = has_win ? level_tbl_i[winner_i] : irq_level_t'(0);
	assign cause_o = has_win ? cause_tbl_i[winner_i] : cause_t'(0);

	// nmi bypasses sensing and the encoder
	assign nmi_o = nmi_i && nmi_en_i;

endmodule

`default_nettype wire

/* src/pic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pic_top
(
	input  wire logic                   clk,
	input  wire logic                   rst_i,
	input  wire logic                   cyc_i,
	input  wire logic                   stb_i,
	input  wire logic                   wr_i,
	input  wire pic_bus_pkg::bus_addr_t adr_i,
	input  wire pic_bus_pkg::bus_data_t dat_i,
	output pic_bus_pkg::bus_data_t      dat_o,
	output logic                        ack_o,
	output logic                        vol_o,
	input  wire pic_irq_pkg::src_vec_t  irq_req_i,
	input  wire logic                   nmi_i,
	output pic_irq_pkg::irq_level_t     irq_o,
	output pic_irq_pkg::cause_t         cause_o,
	output logic                        nmi_o
);

	import pic_irq_pkg::*;

	src_vec_t   sense_req;
	src_vec_t   ie;
	src_vec_t   es;
	src_vec_t   trig;
	src_vec_t   edge_rst;
	src_vec_t   pending;
	src_idx_t   winner;
	irq_level_t [NUM_SRC-1:0] level_tbl;
	cause_t [NUM_SRC-1:0]     cause_tbl;

	// nmi takes the slot of request 0
	assign sense_req = {irq_req_i[NUM_SRC-1:1], nmi_i};

	// ======================================================================
	// input side
	// ======================================================================

	pic_regs u_regs
	(
		.clk         (clk),
		.rst_i       (rst_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.wr_i        (wr_i),
		.adr_i       (adr_i),
		.dat_i       (dat_i),
		.dat_o       (dat_o),
		.ack_o       (ack_o),
		.vol_o       (vol_o),
		.winner_i    (winner),
		.ie_o        (ie),
		.es_o        (es),
		.trig_o      (trig),
		.edge_rst_o  (edge_rst),
		.level_tbl_o (level_tbl),
		.cause_tbl_o (cause_tbl)
	);

	// ======================================================================
	// processing
	// ======================================================================

	pic_sense u_sense
	(
		.clk        (clk),
		.rst_i      (rst_i),
		.req_i      (sense_req),
		.es_i       (es),
		.ie_i       (ie),
		.trig_i     (trig),
		.edge_rst_i (edge_rst),
		.pending_o  (pending)
	);

	pic_prio_enc u_prio_enc
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.pending_i (pending),
		.winner_o  (winner)
	);

	// ======================================================================
	// output side
	// ======================================================================

	// enable bit 0 gates the nmi
	pic_out u_out
	(
		.winner_i    (winner),
		.level_tbl_i (level_tbl),
		.cause_tbl_i (cause_tbl),
		.nmi_en_i    (ie[0]),
		.nmi_i       (nmi_i),
		.irq_o       (irq_o),
		.cause_o     (cause_o),
		.nmi_o       (nmi_o)
	);

endmodule

`default_nettype wire

/* test/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
	output logic clk
);

	// 4 ns period, low for the first half
	localparam real HALF_PERIOD = 2.0;

	initial
	begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* test/tb_pic.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pic;

	import pic_bus_pkg::*;
	import pic_irq_pkg::*;

	localparam logic [31:0] SEED = 32'hff60_a5d4;
	localparam int ACK_TIMEOUT = 16;
	localparam int NO_ACK_CYCLES = 8;

	logic clk;
	logic rst_i;
	logic cyc_i;
	logic stb_i;
	logic wr_i;
	bus_addr_t adr_i;
	bus_data_t dat_i;
	bus_data_t dat_o;
	logic ack_o;
	logic vol_o;
	src_vec_t irq_req_i;
	logic nmi_i;
	irq_level_t irq_o;
	cause_t cause_o;
	logic nmi_o;

	// bookkeeping
	logic [31:0] rng;
	int checks;
	int errors;
	int tests_run;
	int tests_failed;
	int test_err_base;
	string cur_test;

	// reference model state
	src_vec_t m_ie;
	src_vec_t m_es;
	src_vec_t m_latch;
	src_vec_t m_req_prev;
	src_vec_t m_trig;
	src_vec_t m_erst;
	src_vec_t m_pend;
	src_idx_t m_win;
	irq_level_t m_level [NUM_SRC];
	cause_t m_cause [NUM_SRC];
	src_vec_t req_now;
	src_vec_t latch_next;
	src_vec_t pend_next;
	logic bus_wr;
	reg_off_t wr_off;

	tb_clkgen u_clkgen
	(
		.clk (clk)
	);

	pic_top dut_i
	(
		.clk       (clk),
		.rst_i     (rst_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.wr_i      (wr_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.vol_o     (vol_o),
		.irq_req_i (irq_req_i),
		.nmi_i     (nmi_i),
		.irq_o     (irq_o),
		.cause_o   (cause_o),
		.nmi_o     (nmi_o)
	);

	// ======================================================================
	// reference model
	// ======================================================================

	function automatic src_idx_t lowest_source(input src_vec_t v);
		// line 0 never competes
		for (int n = 1; n < NUM_SRC; n++)
		begin
			if (v[n])
				return src_idx_t'(n);
		end
		return '0;
	endfunction

	always @(posedge clk)
	begin
		if (rst_i)
		begin
			m_ie <= '0;
			m_es <= '1;
			m_latch <= '0;
			m_req_prev <= '0;
			m_trig <= '0;
			m_erst <= '0;
			m_pend <= '0;
			m_win <= '0;
			for (int n = 0; n < NUM_SRC; n++)
			begin
				m_level[n] <= 4'h8;
				m_cause[n] <= 8'h00;
			end
		end
		else
		begin
			// snoop register writes off the bus
			bus_wr = cyc_i && stb_i && wr_i && (adr_i[31:8] == PIC_BASE[31:8]);
			wr_off = adr_i[7:2];
			req_now = {irq_req_i[NUM_SRC-1:1], nmi_i};
			// rising edge or trigger sets and edge reset clears
			latch_next = (m_latch | (req_now & ~m_req_prev) | m_trig) & ~m_erst;
			latch_next[0] = 1'b0;
			pend_next = m_ie & ((m_es & latch_next) | (~m_es & req_now));
			pend_next[0] = 1'b0;
			m_latch <= latch_next;
			m_req_prev <= req_now;
			// two stage pipeline with pending then winner
			m_pend <= pend_next;
			m_win <= lowest_source(m_pend);
			m_trig <= (bus_wr && wr_off == REG_TRIG) ? src_vec_t'(1) << dat_i[4:0] : '0;
			m_erst <= (bus_wr && wr_off == REG_EDGE_RST) ? src_vec_t'(1) << dat_i[4:0] : '0;
			if (bus_wr && wr_off[5])
			begin
				m_cause[wr_off[4:0]] <= dat_i[CTL_CAUSE_LSB +: 8];
				m_level[wr_off[4:0]] <= dat_i[CTL_LEVEL_LSB +: 4];
				m_ie[wr_off[4:0]] <= dat_i[CTL_IE_BIT];
				m_es[wr_off[4:0]] <= dat_i[CTL_ES_BIT];
			end
			else if (bus_wr)
			begin
				case (wr_off)
					REG_IE:     m_ie <= dat_i;
					REG_IE_CLR: m_ie[dat_i[4:0]] <= 1'b0;
					REG_IE_SET: m_ie[dat_i[4:0]] <= 1'b1;
					REG_ES:     m_es <= dat_i;
					default:    ;
				endcase
			end
		end
	end

	// ======================================================================
	// helpers
	// ======================================================================

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	// byte address of a register word
	function automatic bus_addr_t reg_addr(input reg_off_t off);
		return {PIC_BASE[31:8], off, 2'b00};
	endfunction

	// control word as the model expects it on a read
	function automatic bus_data_t ctl_expect(input src_idx_t s);
		bus_data_t w;
		w = '0;
		w[CTL_CAUSE_LSB +: 8] = m_cause[s];
		w[CTL_LEVEL_LSB +: 4] = m_level[s];
		w[CTL_IE_BIT] = m_ie[s];
		w[CTL_ES_BIT] = m_es[s];
		return w;
	endfunction

	task automatic check_level(input string label, input irq_level_t exp, input irq_level_t act);
		checks++;
		if (exp !== act)
		begin
			$display("** Error %s %s: expected %h, actual %h", cur_test, label, exp, act);
			errors++;
		end
	endtask

	task automatic check_cause(input string label, input cause_t exp, input cause_t act);
		checks++;
		if (exp !== act)
		begin
			$display("** Error %s %s: expected %h, actual %h", cur_test, label, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string label, input bus_data_t exp, input bus_data_t act);
		checks++;
		if (exp !== act)
		begin
			$display("** Error %s %s: expected %h, actual %h", cur_test, label, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string label, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			$display("** Error %s %s: expected %b, actual %b", cur_test, label, exp, act);
			errors++;
		end
	endtask

	// ack latency in cycles
	task automatic check_cycles(input string label, input int exp, input int act);
		checks++;
		if (exp != act)
		begin
			$display("** Error %s %s: expected %0d, actual %0d", cur_test, label, exp, act);
			errors++;
		end
	endtask

	// cpu side lines against the model a little after the edge
	task automatic compare_outputs(input string label);
		#1;
		check_level(label, (m_win == '0) ? irq_level_t'(0) : m_level[m_win], irq_o);
		check_cause(label, (m_win == '0) ? cause_t'(0) : m_cause[m_win], cause_o);
		check_bit(label, nmi_i && m_ie[0], nmi_o);
	endtask

	// one bus transfer with strobes held until ack or timeout
	task automatic bus_cycle(input logic write, input bus_addr_t addr, input bus_data_t wdata,
		output bus_data_t rdata, output int lat);
		int waited;
		logic got;
		@(negedge clk);
		cyc_i = 1'b1;
		stb_i = 1'b1;
		wr_i = write;
		adr_i = addr;
		dat_i = wdata;
		waited = 0;
		got = 1'b0;
		rdata = '0;
		lat = -1;
		while (!got && waited < ACK_TIMEOUT)
		begin
			#1;
			if (ack_o)
			begin
				got = 1'b1;
				rdata = dat_o;
				lat = waited;
				check_bit("vol with select", 1'b1, vol_o);
			end
			else
			begin
				@(negedge clk);
				waited++;
			end
		end
		if (!got)
		begin
			$display("%s: bus timeout, no ack at address %h", cur_test, addr);
			errors++;
		end
		// hold across the ack edge and release after it
		@(negedge clk);
		cyc_i = 1'b0;
		stb_i = 1'b0;
		wr_i = 1'b0;
	endtask

	task automatic bus_write(input reg_off_t off, input bus_data_t data);
		bus_data_t unused;
		int lat;
		bus_cycle(1'b1, reg_addr(off), data, unused, lat);
	endtask

	task automatic bus_read(input reg_off_t off, output bus_data_t data);
		int lat;
		bus_cycle(1'b0, reg_addr(off), '0, data, lat);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_err_base = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_err_base)
			$display("%s: ok", cur_test);
		else
		begin
			$display("%s: failed with %0d errors", cur_test, errors - test_err_base);
			tests_failed++;
		end
	endtask

	// ======================================================================
	// tests
	// ======================================================================

	task automatic reset_state_test();
		bus_data_t rd;
		start_test("reset_state");
		compare_outputs("outputs");
		check_level("irq", 4'h0, irq_o);
		check_cause("cause", 8'h00, cause_o);
		check_bit("nmi", 1'b0, nmi_o);
		bus_read(REG_IE, rd);
		check_word("ie", 32'h0, rd);
		bus_read(REG_ES, rd);
		check_word("es", 32'hffff_ffff, rd);
		// es set and ie clear with level 8 and cause 0
		for (int n = 0; n < NUM_SRC; n++)
		begin
			bus_read({1'b1, src_idx_t'(n)}, rd);
			check_word("control word", 32'h0002_0800, rd);
		end
		end_test();
	endtask

	task automatic register_test();
		bus_data_t rd;
		logic [31:0] r;
		src_idx_t s;
		start_test("registers");
		for (int i = 0; i < 16; i++)
		begin
			r = next_rand();
			s = r[26:22];
			bus_write({1'b1, s}, r & 32'h0003_ffff);
			bus_read({1'b1, s}, rd);
			check_word("control readback", ctl_expect(s), rd);
		end
		for (int i = 0; i < 8; i++)
		begin
			r = next_rand();
			bus_write(r[5] ? REG_IE_SET : REG_IE_CLR, bus_data_t'(r[4:0]));
			bus_read(REG_IE, rd);
			check_word("ie after command", m_ie, rd);
		end
		bus_write(REG_IE, next_rand());
		bus_read(REG_IE, rd);
		check_word("ie word", m_ie, rd);
		bus_write(REG_ES, next_rand());
		bus_read(REG_ES, rd);
		check_word("es word", m_es, rd);
		end_test();
	endtask

	task automatic level_priority_test();
		bus_data_t rd;
		start_test("level_priority");
		// every line level sensitive with random level and cause
		for (int n = 1; n < NUM_SRC; n++)
			bus_write({1'b1, src_idx_t'(n)}, next_rand() & 32'h0001_ffff);
		bus_write(REG_ES, 32'h0);
		for (int i = 0; i < 24; i++)
		begin
			bus_write(REG_IE, next_rand() | next_rand());
			// sparse pattern so the winner moves around
			irq_req_i = next_rand() & next_rand() & 32'hffff_fffe;
			repeat (2) @(negedge clk);
			compare_outputs("winner outputs");
			bus_read(REG_CAUSE, rd);
			check_word("cause read", (m_win == '0) ? '0 : bus_data_t'(m_cause[m_win]), rd);
		end
		@(negedge clk);
		irq_req_i = '0;
		end_test();
	endtask

	task automatic edge_latch_test();
		src_idx_t s;
		int guard;
		start_test("edge_latch");
		bus_write(REG_IE, 32'hffff_fffe);
		bus_write(REG_ES, 32'hffff_ffff);
		// drop latches left over from the level test
		for (int n = 1; n < NUM_SRC; n++)
			bus_write(REG_EDGE_RST, bus_data_t'(n));
		repeat (3) @(negedge clk);
		compare_outputs("cleared");
		check_level("cleared irq", 4'h0, irq_o);
		for (int i = 0; i < 8; i++)
		begin
			// one cycle pulse before the input drops
			@(negedge clk);
			irq_req_i = next_rand() & next_rand() & 32'hffff_fffe;
			@(negedge clk);
			irq_req_i = '0;
			repeat (3) @(negedge clk);
			compare_outputs("after pulse");
			repeat (4) @(negedge clk);
			compare_outputs("held");
			guard = 0;
			while (m_win != '0 && guard < 40)
			begin
				bus_write(REG_EDGE_RST, bus_data_t'(m_win));
				repeat (3) @(negedge clk);
				compare_outputs("after edge reset");
				guard++;
			end
			if (guard >= 40)
			begin
				$display("%s: edge latches did not drain after 40 resets", cur_test);
				errors++;
			end
			// software trigger without any input
			s = src_idx_t'(next_rand() % 31 + 1);
			bus_write(REG_TRIG, bus_data_t'(s));
			repeat (3) @(negedge clk);
			compare_outputs("after trigger");
			check_cause("trigger cause", m_cause[s], cause_o);
			bus_write(REG_EDGE_RST, bus_data_t'(s));
			repeat (3) @(negedge clk);
			compare_outputs("trigger cleared");
		end
		end_test();
	endtask

	task automatic nmi_test();
		logic [31:0] r;
		start_test("nmi");
		bus_write(REG_IE_CLR, 32'd0);
		nmi_i = 1'b1;
		compare_outputs("masked");
		check_bit("masked nmi", 1'b0, nmi_o);
		bus_write(REG_IE_SET, 32'd0);
		compare_outputs("enabled");
		check_bit("enabled nmi", 1'b1, nmi_o);
		for (int i = 0; i < 12; i++)
		begin
			r = next_rand();
			bus_write(r[1] ? REG_IE_SET : REG_IE_CLR, 32'd0);
			nmi_i = r[0];
			compare_outputs("random nmi");
			check_bit("gated nmi", r[0] & r[1], nmi_o);
			check_level("irq untouched", 4'h0, irq_o);
		end
		@(negedge clk);
		nmi_i = 1'b0;
		end_test();
	endtask

	task automatic bus_timing_test();
		bus_data_t rd;
		int lat;
		logic saw_ack;
		logic saw_vol;
		start_test("bus_timing");
		@(negedge clk);
		#1;
		check_word("idle data", '0, dat_o);
		check_bit("idle ack", 1'b0, ack_o);
		bus_cycle(1'b1, reg_addr(REG_IE), 32'h1234_5678, rd, lat);
		check_cycles("write ack latency", 0, lat);
		bus_cycle(1'b0, reg_addr(REG_IE), '0, rd, lat);
		check_cycles("read ack latency", 1, lat);
		check_word("read data", m_ie, rd);
		// reads then writes outside the window
		for (int k = 0; k < 2; k++)
		begin
			@(negedge clk);
			cyc_i = 1'b1;
			stb_i = 1'b1;
			wr_i = k[0];
			adr_i = PIC_BASE ^ 32'h0001_0000;
			saw_ack = 1'b0;
			saw_vol = 1'b0;
			for (int w = 0; w < NO_ACK_CYCLES; w++)
			begin
				#1;
				if (ack_o)
					saw_ack = 1'b1;
				if (vol_o)
					saw_vol = 1'b1;
				@(negedge clk);
			end
			cyc_i = 1'b0;
			stb_i = 1'b0;
			wr_i = 1'b0;
			if (saw_ack)
			begin
				$display("%s: ack seen for an address outside the controller", cur_test);
				errors++;
			end
			check_bit("vol outside window", 1'b0, saw_vol);
		end
		end_test();
	endtask

	// ======================================================================
	// main sequence
	// ======================================================================

	initial
	begin
		rng = SEED;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err_base = 0;
		cur_test = "init";
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		wr_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		irq_req_i = '0;
		nmi_i = 1'b0;
		repeat (8) @(negedge clk);
		rst_i = 1'b0;
		@(negedge clk);

		reset_state_test();
		register_test();
		level_priority_test();
		edge_latch_test();
		nmi_test();
		bus_timing_test();

		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
src/pic_bus_pkg.sv
src/pic_irq_pkg.sv
src/pic_regs.sv
src/pic_sense.sv
src/pic_prio_enc.sv
src/pic_out.sv
src/pic_top.sv
test/tb_clkgen.sv
test/tb_pic.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it, decide by the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f all.f --top-module tb_pic -o sim_pic &&
./obj_dir/sim_pic > sim.log 2>&1 ||
{ echo "build or run step failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
